// File: design/fb_scale_cfg.svh
// ----------------------------------------
// raster, framebuffer and scale geometry
// ----------------------------------------

`ifndef FB_SCALE_CFG_SVH
`define FB_SCALE_CFG_SVH

// display raster, horizontal, in pixels
`define H_ACTIVE    80      // visible width
`define H_TOTAL     104     // incl. 24 blanking pixels

// display raster, vertical, in lines
`define V_ACTIVE    56      // visible height
`define V_TOTAL     60      // incl. 4 blanking lines

// framebuffer, one 4-bit index per pixel
`define FB_WIDTH    16      // pixels per row, also line buffer length
`define FB_HEIGHT   12      // rows

// each stored pixel shows as FB_SCALE x FB_SCALE screen pixels
// power of two, so divides reduce to shifts
`define FB_SCALE    4

// framebuffer words, FB_WIDTH * FB_HEIGHT
`define FB_PIXELS   192

`endif

// File: design/fb_scale_pkg.sv
// ----------------------------------------
// coordinate, index, colour and address
// types, output pixel struct
// ----------------------------------------

package fb_scale_pkg;

    // screen coordinate, covers the 104 x 60 raster
    typedef logic [7:0] coord_t;

    // colour index into the 16-entry palette
    typedef logic [3:0] cidx_t;

    // 12-bit rgb, 4 bits per channel
    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] colr_t;

    // framebuffer address, row * FB_WIDTH + column
    typedef logic [7:0] fb_addr_t;

    // line buffer column
    typedef logic [3:0] lb_addr_t;

    // pixel leaving the top level
    typedef struct packed {
        coord_t      sx;        // horizontal position
        coord_t      sy;        // vertical position
        logic        de;        // data enable, low in blanking
        logic        frame;     // first pixel of frame
        logic [23:0] rgb;       // 8-bit red, green, blue
    } pix_out_t;

endpackage

// File: design/display_timing.sv
// ----------------------------------------
// raster counters, data enable and
// frame / line start pulses
// ----------------------------------------

`timescale 1ns/100ps
`include "fb_scale_cfg.svh"

module display_timing (
    input  logic                 clk_sys,
    input  logic                 rst,
    output fb_scale_pkg::coord_t sx,        // horizontal position
    output fb_scale_pkg::coord_t sy,        // vertical position
    output logic                 de,        // inside active area
    output logic                 frame,     // one cycle at 0, 0
    output logic                 line       // one cycle at sx 0
);
    import fb_scale_pkg::*;

    localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);    // 103
    localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);    // 59
    localparam coord_t H_ACT  = coord_t'(`H_ACTIVE);
    localparam coord_t V_ACT  = coord_t'(`V_ACTIVE);

    coord_t sx_nxt;     // position on the next clock
    coord_t sy_nxt;

    // raster order, x first then y
    always_comb begin
        sx_nxt = sx + 8'd1;
        sy_nxt = sy;
        if (sx == H_LAST) begin
            sx_nxt = '0;                                    // wrap line
            sy_nxt = (sy == V_LAST) ? '0 : sy + 8'd1;       // wrap frame
        end
    end

    // flags decoded from the next position, so they stay
    // aligned with the registered counters
    // first frame pulse comes one full raster after reset
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            de    <= (sx_nxt < H_ACT) && (sy_nxt < V_ACT);
            frame <= (sx_nxt == '0) && (sy_nxt == '0);
            line  <= (sx_nxt == '0);
        end
    end

endmodule

// File: design/fb_memory.sv
// ----------------------------------------
// framebuffer ram, one write port and
// one registered read port
// ----------------------------------------

`timescale 1ns/100ps
`include "fb_scale_cfg.svh"

module fb_memory (
    input  logic                   clk_sys,
    input  logic                   we,          // write strobe
    input  fb_scale_pkg::fb_addr_t waddr,
    input  fb_scale_pkg::cidx_t    wdata,
    input  fb_scale_pkg::fb_addr_t raddr,
    output fb_scale_pkg::cidx_t    rdata        // valid 1 cycle after raddr
);
    import fb_scale_pkg::*;

    // one colour index per pixel, row-major
    cidx_t mem [`FB_PIXELS];

    // write side, takes effect on the strobe edge
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read side, block ram style output register
    always_ff @(posedge clk_sys) begin
        rdata <= mem[raddr];
    end

endmodule

// File: design/line_scaler.sv
// ----------------------------------------
// row fetch into a line buffer, scaled
// replay of the buffer per line
// ----------------------------------------

`timescale 1ns/100ps
`include "fb_scale_cfg.svh"

module line_scaler (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  fb_scale_pkg::coord_t   sx,          // current raster position
    input  fb_scale_pkg::coord_t   sy,
    output fb_scale_pkg::fb_addr_t fb_raddr,    // framebuffer read address
    input  fb_scale_pkg::cidx_t    fb_rdata,    // 1 cycle after fb_raddr
    output fb_scale_pkg::cidx_t    lb_cidx      // 1 cycle after sx, sy
);
    import fb_scale_pkg::*;

    localparam coord_t   V_LAST   = coord_t'(`V_TOTAL - 1);
    localparam coord_t   FETCH_X  = coord_t'(`H_ACTIVE);            // start of blanking
    localparam coord_t   IMG_H    = coord_t'(`FB_HEIGHT * `FB_SCALE); // 48 lines
    localparam coord_t   SC_MASK  = coord_t'(`FB_SCALE - 1);
    localparam lb_addr_t COL_LAST = lb_addr_t'(`FB_WIDTH - 1);

    coord_t   ny;           // line after the current one
    logic     fetch_go;     // start a row burst this cycle
    coord_t   fetch_row;    // framebuffer row for next line
    logic     fetch_act;    // burst in progress
    lb_addr_t fetch_col;    // column of the address on fb_raddr
    logic     wr_vld;       // fb_rdata holds a fetched word
    lb_addr_t wr_col;       // its column
    lb_addr_t rd_col;       // display side column

    cidx_t lbuf [`FB_WIDTH];    // one framebuffer row

    // fetch decision, taken once per line at the blanking start
    always_comb begin
        ny        = (sy == V_LAST) ? '0 : sy + 8'd1;   // wraps into line 0
        // only the first of each group of FB_SCALE lines needs a new row
        fetch_go  = (sx == FETCH_X) && (ny < IMG_H) && ((ny & SC_MASK) == '0);
        fetch_row = coord_t'(ny / `FB_SCALE);
    end

    // burst control, 16 reads back to back
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            fetch_act <= 1'b0;
            fetch_col <= '0;
            wr_vld    <= 1'b0;
        end else begin
            if (fetch_go) begin
                fetch_act <= 1'b1;
                fetch_col <= '0;
            end else if (fetch_act) begin
                fetch_col <= fetch_col + 4'd1;
                if (fetch_col == COL_LAST) begin
                    fetch_act <= 1'b0;          // last address issued
                end
            end
            wr_vld <= fetch_act;    // ram read latency
        end
    end

    // read address walks the row from its base
    always_ff @(posedge clk_sys) begin
        if (fetch_go) begin
            fb_raddr <= fb_addr_t'(fetch_row * `FB_WIDTH);   // row base
        end else if (fetch_act) begin
            fb_raddr <= fb_raddr + 8'd1;
        end
        wr_col <= fetch_col;    // follows the word through the ram
    end

    // capture returning words
    // burst ends by sx 98, well before the next active line
    always_ff @(posedge clk_sys) begin
        if (wr_vld) begin
            lbuf[wr_col] <= fb_rdata;
        end
    end

    // horizontal replication, each column held for FB_SCALE pixels
    // columns past the image wrap, paint blanks them anyway
    always_comb begin
        rd_col = lb_addr_t'(sx / `FB_SCALE);
    end

    // vertical replication comes for free, the buffer
    // is only refilled every FB_SCALE lines
    always_ff @(posedge clk_sys) begin
        lb_cidx <= lbuf[rd_col];
    end

endmodule

// File: design/clut.sv
// ----------------------------------------
// 16-entry palette, write port and
// registered lookup
// ----------------------------------------

`timescale 1ns/100ps

module clut (
    input  logic                clk_sys,
    input  logic                we,         // palette write strobe
    input  fb_scale_pkg::cidx_t widx,       // entry to write
    input  fb_scale_pkg::colr_t wcolr,      // new 12-bit colour
    input  fb_scale_pkg::cidx_t ridx,       // lookup index
    output fb_scale_pkg::colr_t colr        // 1 cycle after ridx
);
    import fb_scale_pkg::*;

    localparam int PAL_SIZE = 2 ** $bits(cidx_t);   // one entry per index

    // contents unknown until written
    colr_t pal [PAL_SIZE];

    // entry update
    always_ff @(posedge clk_sys) begin
        if (we) begin
            pal[widx] <= wcolr;
        end
    end

    // lookup, new entries seen on the next read
    always_ff @(posedge clk_sys) begin
        colr <= pal[ridx];
    end

endmodule

// File: design/fb_scale_top.sv
// ----------------------------------------
// scaled framebuffer display top level,
// coordinate delay and paint register
// ----------------------------------------

`timescale 1ns/100ps
`include "fb_scale_cfg.svh"

module fb_scale_top (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   fb_we,       // framebuffer write
    input  fb_scale_pkg::fb_addr_t fb_waddr,
    input  fb_scale_pkg::cidx_t    fb_wdata,
    input  logic                   pal_we,      // palette write
    input  fb_scale_pkg::cidx_t    pal_widx,
    input  fb_scale_pkg::colr_t    pal_wcolr,
    output fb_scale_pkg::pix_out_t pix          // 3 cycles behind the raster
);
    import fb_scale_pkg::*;

    // raster state carried alongside the colour pipeline
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   de;
        logic   frame;
    } rast_t;

    localparam coord_t IMG_W = coord_t'(`FB_WIDTH * `FB_SCALE);     // 64
    localparam coord_t IMG_H = coord_t'(`FB_HEIGHT * `FB_SCALE);    // 48

    coord_t   sx;
    coord_t   sy;
    logic     de;
    logic     frame;
    logic     line;         // line start, seen by the bound checks
    fb_addr_t fb_raddr;
    cidx_t    fb_rdata;
    cidx_t    lb_cidx;
    colr_t    colr;
    rast_t    dly [2];      // line buffer read + clut lookup
    logic     paint_on;     // inside active area and scaled image
    colr_t    paint_colr;

    display_timing i_display_timing (
        .clk_sys (clk_sys),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .frame   (frame),
        .line    (line)
    );

    fb_memory i_fb_memory (
        .clk_sys (clk_sys),
        .we      (fb_we),
        .waddr   (fb_waddr),
        .wdata   (fb_wdata),
        .raddr   (fb_raddr),
        .rdata   (fb_rdata)
    );

    line_scaler i_line_scaler (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .sx       (sx),
        .sy       (sy),
        .fb_raddr (fb_raddr),
        .fb_rdata (fb_rdata),
        .lb_cidx  (lb_cidx)
    );

    clut i_clut (
        .clk_sys (clk_sys),
        .we      (pal_we),
        .widx    (pal_widx),
        .wcolr   (pal_wcolr),
        .ridx    (lb_cidx),
        .colr    (colr)
    );

    // two stages, matches lb_cidx then colr
    always_ff @(posedge clk_sys) begin
        dly[0] <= {sx, sy, de, frame};
        dly[1] <= dly[0];
    end

    // black outside the 64 x 48 image and in blanking
    always_comb begin
        paint_on   = dly[1].de && (dly[1].sx < IMG_W) && (dly[1].sy < IMG_H);
        paint_colr = paint_on ? colr : '0;
    end

    // output register, each channel doubled 4 -> 8 bits
    always_ff @(posedge clk_sys) begin
        pix.sx  <= dly[1].sx;
        pix.sy  <= dly[1].sy;
        pix.rgb <= {{2{paint_colr[11:8]}}, {2{paint_colr[7:4]}}, {2{paint_colr[3:0]}}};
        if (rst) begin
            pix.de    <= 1'b0;
            pix.frame <= 1'b0;
        end else begin
            pix.de    <= dly[1].de;
            pix.frame <= dly[1].frame;
        end
    end

endmodule

// File: tests/fb_scale_assert.sv
// ----------------------------------------
// bound checks on frame and line pulses
// and output blanking
// ----------------------------------------

`timescale 1ns/100ps

module fb_scale_assert (
    input logic                   clk_sys,
    input logic                   rst,
    input logic                   frame,    // raster frame pulse, before the pipe
    input logic                   line,     // raster line pulse
    input fb_scale_pkg::pix_out_t pix       // registered output pixel
);

    logic [2:0] run_q;      // shifts in ones once reset is gone

    // output pipe has no reset, wait until it holds raster data
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            run_q <= '0;
        end else begin
            run_q <= {run_q[1:0], 1'b1};
        end
    end

    raster_frame_one_cycle: assert property (@(posedge clk_sys) disable iff (rst)
        frame |=> !frame)
        else $error("raster frame pulse longer than one cycle");

    raster_line_one_cycle: assert property (@(posedge clk_sys) disable iff (rst)
        line |=> !line)
        else $error("raster line pulse longer than one cycle");

    // frame start is also a line start
    frame_with_line: assert property (@(posedge clk_sys) disable iff (rst)
        frame |-> line)
        else $error("raster frame pulse without line pulse");

    pix_frame_one_cycle: assert property (@(posedge clk_sys) disable iff (rst)
        pix.frame |=> !pix.frame)
        else $error("output frame flag longer than one cycle");

    pix_frame_at_origin: assert property (@(posedge clk_sys) disable iff (rst)
        pix.frame |-> (pix.sx == '0) && (pix.sy == '0))
        else $error("output frame flag away from pixel 0, 0");

    blank_when_no_de: assert property (@(posedge clk_sys) disable iff (rst || !run_q[2])
        !pix.de |-> (pix.rgb == '0))
        else $error("colour present while data enable is low");

endmodule

bind fb_scale_top fb_scale_assert i_fb_scale_assert (
    .clk_sys (clk_sys),
    .rst     (rst),
    .frame   (frame),
    .line    (line),
    .pix     (pix)
);

// File: tests/fb_scale_tb.sv
// ----------------------------------------
// testbench for the scaled framebuffer,
// file-driven loading and per-pixel checks
// ----------------------------------------

`timescale 1ns/100ps
`include "fb_scale_cfg.svh"

module fb_scale_tb;
    import fb_scale_pkg::*;

    localparam int     FRAME_CYC = `H_TOTAL * `V_TOTAL;        // 6240 cycles per frame
    localparam int     MAX_CMD   = 64;                         // command words in the file
    localparam coord_t H_LAST    = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST    = coord_t'(`V_TOTAL - 1);
    localparam coord_t H_ACT     = coord_t'(`H_ACTIVE);
    localparam coord_t V_ACT     = coord_t'(`V_ACTIVE);
    localparam coord_t IMG_W     = coord_t'(`FB_WIDTH * `FB_SCALE);   // 64
    localparam coord_t IMG_H     = coord_t'(`FB_HEIGHT * `FB_SCALE);  // 48

    logic     clk_sys = 1'b0;
    logic     rst;
    logic     fb_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata;
    logic     pal_we;
    cidx_t    pal_widx;
    colr_t    pal_wcolr;
    pix_out_t pix;

    logic [31:0] cmd_mem [MAX_CMD];     // command words, see input file
    colr_t       pal_m [16];            // model palette
    cidx_t       fb_m [`FB_PIXELS];     // model framebuffer
    integer      seed     = 32'h9e62;
    int          n_frames = 0;          // frames to check
    int          load_cyc = 0;          // cycles spent writing
    int          wd_limit;
    logic        wd_armed = 1'b0;
    coord_t      exp_x;                 // model raster position
    coord_t      exp_y;

    fb_scale_top i_fb_scale_top (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .fb_we     (fb_we),
        .fb_waddr  (fb_waddr),
        .fb_wdata  (fb_wdata),
        .pal_we    (pal_we),
        .pal_widx  (pal_widx),
        .pal_wcolr (pal_wcolr),
        .pix       (pix)
    );

    always #5 clk_sys = ~clk_sys;       // 10 ns period

    // value mismatch, stops at the first one
    task automatic report_value(input string name, input logic [31:0] expv,
                                input logic [31:0] actv);
        $display("FAILED %s expected %0h actual %0h at x %0d y %0d",
                 name, expv, actv, pix.sx, pix.sy);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped on bad setup");
    endtask

    // one write per cycle, the other port idles
    task automatic write_fb(input fb_addr_t a, input cidx_t d);
        @(negedge clk_sys);
        fb_we    = 1'b1;
        fb_waddr = a;
        fb_wdata = d;
        pal_we   = 1'b0;
        fb_m[a]  = d;       // model follows the dut
    endtask

    task automatic write_pal(input cidx_t i, input colr_t c);
        @(negedge clk_sys);
        pal_we    = 1'b1;
        pal_widx  = i;
        pal_wcolr = c;
        fb_we     = 1'b0;
        pal_m[i]  = c;
    endtask

    // frame count and load length, before the run starts
    task automatic scan_commands();
        for (int i = 0; i < MAX_CMD; i++) begin
            case (cmd_mem[6'(i)][31:28])
                4'h1, 4'h2: load_cyc += 1;
                4'h3:       load_cyc += `FB_PIXELS;
                4'h4:       n_frames = int'(cmd_mem[6'(i)][7:0]);
                default:    ;                       // blank or end of file
            endcase
        end
    endtask

    // palette, explicit writes and random fill in file order
    task automatic run_commands();
        logic [31:0] w;
        cidx_t       v;
        for (int i = 0; i < MAX_CMD; i++) begin
            w = cmd_mem[6'(i)];
            case (w[31:28])
                4'h1: write_pal(w[15:12], w[11:0]);
                4'h2: write_fb(w[15:8], w[3:0]);
                4'h3: begin
                    for (int a = 0; a < `FB_PIXELS; a++) begin
                        v = cidx_t'($random(seed));
                        write_fb(fb_addr_t'(a), v);
                    end
                end
                default: ;
            endcase
        end
        @(negedge clk_sys);
        fb_we  = 1'b0;
        pal_we = 1'b0;
    endtask

    // model colour, each channel doubled, black outside the image
    function automatic logic [23:0] expect_rgb(input coord_t x, input coord_t y,
                                               input logic in_img);
        colr_t    c;
        fb_addr_t a;
        c = '0;
        if (in_img) begin
            a = fb_addr_t'((y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE);
            c = pal_m[fb_m[a]];
        end
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    // two frame starts, the second opens the checked window
    // cycles between them give the frame period
    task automatic wait_frames();
        int gap;
        @(negedge clk_sys);
        while (!pix.frame) @(negedge clk_sys);
        gap = 1;
        @(negedge clk_sys);
        while (!pix.frame) begin
            @(negedge clk_sys);
            gap++;
        end
        assert (gap == FRAME_CYC) else report_value("frame_period", FRAME_CYC, gap);
    endtask

    task automatic check_cycle();
        logic        exp_de;
        logic        exp_fr;
        logic        in_img;
        logic [23:0] exp_rgb;
        string       rgb_name;
        exp_de  = (exp_x < H_ACT) && (exp_y < V_ACT);
        exp_fr  = (exp_x == '0) && (exp_y == '0);
        in_img  = exp_de && (exp_x < IMG_W) && (exp_y < IMG_H);
        exp_rgb = expect_rgb(exp_x, exp_y, in_img);
        if (in_img) begin
            rgb_name = "scaled_rgb";
        end else begin
            rgb_name = "border_black";
        end
        assert (pix.sx == exp_x) else report_value("raster_x", 32'(exp_x), 32'(pix.sx));
        assert (pix.sy == exp_y) else report_value("raster_y", 32'(exp_y), 32'(pix.sy));
        assert (pix.frame == exp_fr)
            else report_value("frame_flag", 32'(exp_fr), 32'(pix.frame));
        assert (pix.de == exp_de) else report_value("data_enable", 32'(exp_de), 32'(pix.de));
        assert (pix.rgb == exp_rgb) else report_value(rgb_name, 32'(exp_rgb), 32'(pix.rgb));
        // raster order, wrap at 104 and 60
        if (exp_x == H_LAST) begin
            exp_x = '0;
            exp_y = (exp_y == V_LAST) ? '0 : exp_y + 8'd1;
        end else begin
            exp_x = exp_x + 8'd1;
        end
    endtask

    // watchdog, armed once the file gives the run length
    initial begin
        wait (wd_armed);
        repeat (wd_limit) @(posedge clk_sys);
        $display("timeout, the checked frames did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        fb_we     = 1'b0;
        fb_waddr  = '0;
        fb_wdata  = '0;
        pal_we    = 1'b0;
        pal_widx  = '0;
        pal_wcolr = '0;
        for (int i = 0; i < MAX_CMD; i++) cmd_mem[6'(i)] = '0;
        $readmemh("tests/fb_scale_input.txt", cmd_mem);
        scan_commands();
        assert (n_frames > 0) else fail_plain("input file gives no frame count");
        wd_limit = (n_frames + 3) * FRAME_CYC + load_cyc;
        wd_armed = 1'b1;
        repeat (3) @(negedge clk_sys);      // 3 reset cycles
        rst = 1'b0;
        run_commands();
        wait_frames();
        exp_x = '0;
        exp_y = '0;
        for (int n = 0; n < n_frames * FRAME_CYC; n++) begin
            check_cycle();
            @(negedge clk_sys);
        end
        // every failing check stops the run, so reaching here is clean
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tests/fb_scale_input.txt
// 1000iccc palette entry i gets colour ccc, 2000aa0i framebuffer address aa gets index i
// 30000000 random fill of all addresses, 400000nn check nn frames
10000000
10001F00
100020F0
1000300F
10004FF0
10005F0F
100060FF
10007FFF
10008800
10009080
1000A008
1000B888
1000CF80
1000D08F
1000E8F0
1000FF08
30000000
20000001    // corner top left
20000F05    // corner top right
2000B009    // corner bottom left
2000BF0C    // corner bottom right
20005505
10005ABC    // palette rewrite after the fill
40000003

// File: fb_scale_top.f
+incdir+design
design/fb_scale_pkg.sv
design/display_timing.sv
design/fb_memory.sv
design/line_scaler.sv
design/clut.sv
design/fb_scale_top.sv
tests/fb_scale_assert.sv
tests/fb_scale_tb.sv

// File: Makefile
# Verilator build and run of the scaled framebuffer testbench

SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: run clean

run: obj_dir/Vfb_scale_tb
	obj_dir/Vfb_scale_tb

obj_dir/Vfb_scale_tb: fb_scale_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module fb_scale_tb -f fb_scale_top.f

clean:
	rm -rf obj_dir
